// File: verilog.f
+incdir+include
verilog/exec_pkg.sv
verilog/exec_issue_if.sv
verilog/id_ex_capture.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/ex_mem_register.sv
verilog/execute_stage.sv
testbench/execute_stage_asserts.sv
testbench/tb_execute_stage.sv

// File: Bender.yml
package:
  name: execute_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/exec_pkg.sv
      - verilog/exec_issue_if.sv
      - verilog/id_ex_capture.sv
      - verilog/alu.sv
      - verilog/branch_unit.sv
      - verilog/ex_mem_register.sv
      - verilog/execute_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/execute_stage_asserts.sv
      - testbench/tb_execute_stage.sv

// File: testbench/tb_execute_stage.sv
// Directed testbench for execute_stage, run from the simulator with verilog.f as the file list
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module tb_execute_stage import exec_pkg::*; ();

    typedef logic [`EX_XLEN-1:0] word_t;

    // Roughly 130 cycles of tests, doubled for margin
    localparam int MAX_CYCLES = 260;

    logic                  clk;
    logic                  rst;
    logic                  stall;
    word_t                 rs1_value, rs2_value, imm, pc, mem_wb_data;
    logic [`EX_REG_AW-1:0] rs1_addr, rs2_addr, rd, mem_wb_rd;
    logic                  alu_src, pc_src, mem_write, mem_read, reg_write, mem_to_reg;
    logic                  mem_wb_reg_write;
    operand_mode_e         mode;
    alu_ctrl_e             alu_ctrl;
    branch_type_e          branch_type;

    word_t                 ex_result, ex_store_data, ex_branch_target;
    logic                  ex_branch_taken, ex_mem_write, ex_mem_read, ex_reg_write, ex_mem_to_reg;
    logic [`EX_REG_AW-1:0] ex_rd;
    logic [8:0]            ctrl_out;

    string                 test_name;
    int                    test_errors;
    int                    errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    cycles = 0;
    logic [31:0]           lfsr_state = 32'hb06c;

    assign ctrl_out = {ex_mem_write, ex_mem_read, ex_reg_write, ex_mem_to_reg, ex_rd};

    execute_stage u_dut (.*);

    bind execute_stage execute_stage_asserts u_asserts (
        .clk(clk), .rst(rst), .stall(stall), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .cap_rs1(issue.rs1), .cap_rs2(issue.rs2),
        .outs({ex_result, ex_store_data, ex_branch_taken, ex_branch_target, ex_mem_write,
               ex_mem_read, ex_reg_write, ex_mem_to_reg, ex_rd})
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Run stopped after %0d clock cycles without finishing the tests", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_word();
        word_t w;
        int    i;
        begin
            w = '0;
            for (i = 0; i < `EX_XLEN; i++)
            begin
                lfsr_state = lfsr_step(lfsr_state);
                w = {w[`EX_XLEN-2:0], lfsr_state[0]};
            end
            return w;
        end
    endfunction

    // Reference ALU from the operand mode table
    function automatic word_t alu_model(input operand_mode_e m, input alu_ctrl_e c,
                                        input logic src, input word_t r1, input word_t r2,
                                        input word_t im, input word_t p);
        word_t a;
        word_t b;
        begin
            a = (m == MODE_LUI) ? im : (m inside {MODE_AUIPC, MODE_JAL, MODE_JALR}) ? p : r1;
            case (m)
                MODE_LUI:            b = '0;
                MODE_JAL, MODE_JALR: b = `EX_LINK_OFFSET;
                MODE_BRANCH:         b = r2;
                MODE_REG_IMM:        b = src ? im : r2;
                default:             b = im;  // Load/store and AUIPC
            endcase
            case (c)
                ALU_ADD:  return a + b;
                ALU_SUB:  return a - b;
                ALU_AND:  return a & b;
                ALU_OR:   return a | b;
                ALU_XOR:  return a ^ b;
                ALU_SLL:  return a << b[4:0];
                ALU_SRL:  return a >> b[4:0];
                ALU_SRA:  return $signed(a) >>> b[4:0];
                ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
                ALU_SLTU: return (a < b) ? 1 : 0;
                default:  return '0;
            endcase
        end
    endfunction

    function automatic logic branch_model(input branch_type_e t, input word_t r1, input word_t r2);
        case (t)
            BR_BEQ:  return r1 == r2;
            BR_BNE:  return r1 != r2;
            BR_BLT:  return $signed(r1) < $signed(r2);
            BR_BGE:  return $signed(r1) >= $signed(r2);
            BR_BLTU: return r1 < r2;
            default: return r1 >= r2;  // BGEU
        endcase
    endfunction

    task automatic check(input string what, input word_t expected, input word_t actual);
        begin
            if (actual !== expected)
            begin
                $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic start_test(input string name);
        begin
            test_name = name;
            test_errors = 0;
            tests_run++;
        end
    endtask

    task automatic end_test();
        begin
            if (test_errors != 0)
                tests_failed++;
            $display("%-20s %s, %0d mismatches", test_name, (test_errors == 0) ? "ok" : "failed",
                     test_errors);
        end
    endtask

    // One operation with no forwarding, no memory access and no writeback
    task automatic drive_op(input operand_mode_e m, input alu_ctrl_e c, input logic src,
                            input word_t r1, input word_t r2, input word_t im, input word_t p);
        begin
            mode = m;
            alu_ctrl = c;
            alu_src = src;
            rs1_value = r1;
            rs2_value = r2;
            imm = im;
            pc = p;
            branch_type = BR_BEQ;
            mem_wb_data = '0;
            {rs1_addr, rs2_addr, rd, mem_wb_rd} = '0;
            {pc_src, mem_write, mem_read, reg_write, mem_to_reg, mem_wb_reg_write, stall} = '0;
        end
    endtask

    // Two clock edges through both registers, sampled on the falling edge
    task automatic await_result();
        begin
            repeat (2) @(posedge clk);
            @(negedge clk);
        end
    endtask

    task automatic alu_case(input operand_mode_e m, input alu_ctrl_e c, input logic src);
        word_t r1, r2, im, p;
        begin
            r1 = rand_word();
            r2 = rand_word();
            im = rand_word();
            p = rand_word();
            drive_op(m, c, src, r1, r2, im, p);
            await_result();
            check($sformatf("%s/%s/src=%0d", m.name(), c.name(), src),
                  alu_model(m, c, src, r1, r2, im, p), ex_result);
        end
    endtask

    // LUI puts value on the EX/MEM result, then a bubble so it is in EX/MEM at the consumer
    task automatic produce(input logic [`EX_REG_AW-1:0] dest, input word_t value);
        begin
            drive_op(MODE_LUI, ALU_ADD, 1'b0, '0, '0, value, '0);
            rd = dest;
            reg_write = 1'b1;
            @(negedge clk);
            drive_op(MODE_LOAD_STORE, ALU_ADD, 1'b0, '0, '0, '0, '0);
            @(negedge clk);
        end
    endtask

    task automatic after_reset();
        begin
            start_test("after_reset");
            check("result", '0, ex_result);
            check("store_data", '0, ex_store_data);
            check("target", '0, ex_branch_target);
            check("controls", '0, {ex_branch_taken, ctrl_out});
            end_test();
        end
    endtask

    task automatic alu_ops();
        int k;
        int s;
        begin
            start_test("alu_ops");
            for (k = 0; k < 10; k++)
                for (s = 0; s < 2; s++)
                    alu_case(MODE_REG_IMM, alu_ctrl_e'(k), s[0]);
            alu_case(MODE_LOAD_STORE, ALU_ADD, 1'b0);
            alu_case(MODE_BRANCH, ALU_SUB, 1'b0);
            alu_case(MODE_LUI, ALU_ADD, 1'b0);
            alu_case(MODE_AUIPC, ALU_ADD, 1'b0);
            alu_case(MODE_JAL, ALU_ADD, 1'b0);
            alu_case(MODE_JALR, ALU_ADD, 1'b0);
            end_test();
        end
    endtask

    task automatic operand_forwarding();
        word_t p, w, v, im;
        begin
            start_test("operand_forwarding");
            p = rand_word();
            w = rand_word();
            v = rand_word();
            im = rand_word();
            produce(5'd5, p);
            drive_op(MODE_REG_IMM, ALU_ADD, 1'b1, v, '0, im, '0);  // Stale x5 in rs1_value
            rs1_addr = 5'd5;
            await_result();
            check("ex_mem", p + im, ex_result);
            produce(5'd5, p);
            drive_op(MODE_REG_IMM, ALU_ADD, 1'b1, v, '0, im, '0);
            rs1_addr = 5'd5;
            {mem_wb_reg_write, mem_wb_rd, mem_wb_data} = {1'b1, 5'd5, w};
            await_result();
            check("both_match", p + im, ex_result);
            produce(5'd7, p);  // EX/MEM writes x7, MEM/WB writes x6
            drive_op(MODE_REG_IMM, ALU_SUB, 1'b0, v, ~w, im, '0);
            rs2_addr = 5'd6;
            {mem_wb_reg_write, mem_wb_rd, mem_wb_data} = {1'b1, 5'd6, w};
            await_result();
            check("mem_wb", v - w, ex_result);
            check("mem_wb_store", w, ex_store_data);
            produce(5'd0, p);
            drive_op(MODE_REG_IMM, ALU_ADD, 1'b1, v, '0, im, '0);
            {mem_wb_reg_write, mem_wb_rd, mem_wb_data} = {1'b1, 5'd0, w};
            await_result();
            check("x0", v + im, ex_result);
            end_test();
        end
    endtask

    task automatic branch_and_jump();
        branch_type_e types[6];
        word_t        lhs[3];
        word_t        rhs[3];
        word_t        p, im, r1;
        int           t;
        int           k;
        begin
            start_test("branch_and_jump");
            types = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
            r1 = rand_word();
            lhs = '{r1, 32'h8000_0000, 32'h0000_0001};  // Equal, then signed/unsigned edges
            rhs = '{r1, 32'h0000_0001, 32'h8000_0000};
            for (t = 0; t < 6; t++)
            begin
                for (k = 0; k < 3; k++)
                begin
                    p = rand_word();
                    im = rand_word();
                    drive_op(MODE_BRANCH, ALU_SUB, 1'b0, lhs[k], rhs[k], im, p);
                    branch_type = types[t];
                    pc_src = 1'b1;
                    await_result();
                    check($sformatf("%s/%0d taken", types[t].name(), k),
                          branch_model(types[t], lhs[k], rhs[k]), ex_branch_taken);
                    check($sformatf("%s/%0d target", types[t].name(), k), p + im,
                          ex_branch_target);
                end
            end
            drive_op(MODE_BRANCH, ALU_SUB, 1'b0, r1, r1, im, p);  // BEQ holds, but no pc_src
            await_result();
            check("no_pc_src", '0, ex_branch_taken);
            p = rand_word();
            im = rand_word();
            drive_op(MODE_JAL, ALU_ADD, 1'b0, r1, r1, im, p);
            branch_type = BR_BNE;  // Condition false, jump taken anyway
            pc_src = 1'b1;
            await_result();
            check("jal taken", 1, ex_branch_taken);
            check("jal target", p + im, ex_branch_target);
            check("jal link", p + `EX_LINK_OFFSET, ex_result);
            r1 = rand_word() | 32'h1;
            im = rand_word() & 32'hffff_fffe;  // Odd sum
            drive_op(MODE_JALR, ALU_ADD, 1'b0, r1, '0, im, p);
            pc_src = 1'b1;
            await_result();
            check("jalr taken", 1, ex_branch_taken);
            check("jalr target", (r1 + im) & 32'hffff_fffe, ex_branch_target);
            check("jalr link", p + `EX_LINK_OFFSET, ex_result);
            end_test();
        end
    endtask

    task automatic stall_freeze();
        word_t a1, b1, a2, b2;
        begin
            start_test("stall_freeze");
            a1 = rand_word();
            b1 = rand_word();
            a2 = rand_word();
            b2 = rand_word();
            drive_op(MODE_REG_IMM, ALU_ADD, 1'b1, a1, '0, b1, '0);
            rd = 5'd1;
            @(negedge clk);
            drive_op(MODE_REG_IMM, ALU_ADD, 1'b1, a2, '0, b2, '0);
            rd = 5'd2;
            @(negedge clk);
            drive_op(MODE_REG_IMM, ALU_XOR, 1'b1, a1, '0, b2, '0);
            rd = 5'd3;
            stall = 1'b1;  // First op in EX/MEM, second in ID/EX
            repeat (4)
            begin
                @(negedge clk);
                check("held result", a1 + b1, ex_result);
                check("held rd", 1, ex_rd);
            end
            stall = 1'b0;
            @(negedge clk);
            check("second result", a2 + b2, ex_result);
            check("second rd", 2, ex_rd);
            @(negedge clk);
            check("third result", a1 ^ b2, ex_result);
            check("third rd", 3, ex_rd);
            end_test();
        end
    endtask

    task automatic control_passthrough();
        word_t r1, r2, im;
        begin
            start_test("control_passthrough");
            r1 = rand_word();
            r2 = rand_word();
            im = rand_word();
            drive_op(MODE_LOAD_STORE, ALU_ADD, 1'b0, r1, r2, im, '0);
            mem_write = 1'b1;
            await_result();
            check("store addr", r1 + im, ex_result);
            check("store data", r2, ex_store_data);
            check("store ctrl", 9'b1_0_0_0_00000, ctrl_out);
            drive_op(MODE_LOAD_STORE, ALU_ADD, 1'b0, r1, r2, im, '0);
            {mem_read, mem_to_reg, reg_write, rd} = {3'b111, 5'd17};
            await_result();
            check("load addr", r1 + im, ex_result);
            check("load ctrl", {4'b0111, 5'd17}, ctrl_out);
            end_test();
        end
    endtask

    initial
    begin
        drive_op(MODE_LOAD_STORE, ALU_ADD, 1'b0, '0, '0, '0, '0);
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        after_reset();
        alu_ops();
        operand_forwarding();
        branch_and_jump();
        stall_freeze();
        control_passthrough();
        $display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/execute_stage_asserts.sv
// Concurrent checks on reset, stall hold and x0 forwarding, bound into execute_stage by the testbench
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module execute_stage_asserts (
    input wire                               clk,
    input wire                               rst,
    input wire                               stall,
    input wire [`EX_REG_AW-1:0]              rs1_addr,
    input wire [`EX_REG_AW-1:0]              rs2_addr,
    input wire [`EX_XLEN-1:0]                rs1_value,
    input wire [`EX_XLEN-1:0]                rs2_value,
    input wire [`EX_XLEN-1:0]                cap_rs1,   // ID/EX operands after forwarding
    input wire [`EX_XLEN-1:0]                cap_rs2,
    input wire [3*`EX_XLEN+`EX_REG_AW+4:0]   outs       // All nine stage outputs
);

    // Registers cleared on the edge after rst is seen
    reset_clears: assert property (@(posedge clk) rst |=> (outs == '0))
        else $error("stage outputs not zero while reset is held");

    stall_holds: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(outs))
        else $error("stage outputs changed while stall was high");

    // x0 reads keep the register file value, even when EX/MEM or MEM/WB writes rd 0
    x0_rs1_unforwarded: assert property (@(posedge clk) disable iff (rst)
        (!stall && rs1_addr == '0) |=> (cap_rs1 == $past(rs1_value)))
        else $error("rs1 read of x0 took a forwarded value");

    x0_rs2_unforwarded: assert property (@(posedge clk) disable iff (rst)
        (!stall && rs2_addr == '0) |=> (cap_rs2 == $past(rs2_value)))
        else $error("rs2 read of x0 took a forwarded value");

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
// Execute stage top level, ID/EX capture feeding ALU and branch unit into the EX/MEM register
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module execute_stage import exec_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,          // Level, holds both registers

    input  wire [`EX_XLEN-1:0]    rs1_value,
    input  wire [`EX_XLEN-1:0]    rs2_value,
    input  wire [`EX_XLEN-1:0]    imm,
    input  wire [`EX_XLEN-1:0]    pc,
    input  wire [`EX_REG_AW-1:0]  rs1_addr,
    input  wire [`EX_REG_AW-1:0]  rs2_addr,
    input  wire                   alu_src,
    input  wire operand_mode_e    mode,
    input  wire alu_ctrl_e        alu_ctrl,
    input  wire branch_type_e     branch_type,
    input  wire                   pc_src,
    input  wire                   mem_write,
    input  wire                   mem_read,
    input  wire                   reg_write,
    input  wire                   mem_to_reg,
    input  wire [`EX_REG_AW-1:0]  rd,

    // Writeback stage forwarding source
    input  wire                   mem_wb_reg_write,
    input  wire [`EX_REG_AW-1:0]  mem_wb_rd,
    input  wire [`EX_XLEN-1:0]    mem_wb_data,

    output logic [`EX_XLEN-1:0]   ex_result,
    output logic [`EX_XLEN-1:0]   ex_store_data,
    output logic                  ex_branch_taken,
    output logic [`EX_XLEN-1:0]   ex_branch_target,
    output logic                  ex_mem_write,
    output logic                  ex_mem_read,
    output logic                  ex_reg_write,
    output logic                  ex_mem_to_reg,
    output logic [`EX_REG_AW-1:0] ex_rd
);

    logic [`EX_XLEN-1:0] alu_result;
    logic                br_taken;
    logic [`EX_XLEN-1:0] br_target;

    exec_issue_if issue ();

    // EX/MEM outputs loop back as the nearer forwarding source
    id_ex_capture u_capture (
        .clk(clk), .rst(rst), .stall(stall),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm), .pc(pc),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .alu_src(alu_src), .mode(mode),
        .alu_ctrl(alu_ctrl), .branch_type(branch_type), .pc_src(pc_src),
        .mem_write(mem_write), .mem_read(mem_read), .reg_write(reg_write),
        .mem_to_reg(mem_to_reg), .rd(rd),
        .fwd_reg_write(ex_reg_write), .fwd_rd(ex_rd), .fwd_result(ex_result),
        .mem_wb_reg_write(mem_wb_reg_write), .mem_wb_rd(mem_wb_rd), .mem_wb_data(mem_wb_data),
        .issue(issue.capture)
    );

    alu u_alu (.issue(issue.alu), .result(alu_result));

    branch_unit u_branch (.issue(issue.branch), .taken(br_taken), .target(br_target));

    ex_mem_register u_ex_mem (
        .clk(clk), .rst(rst), .stall(stall), .issue(issue.commit),
        .result(alu_result), .taken(br_taken), .target(br_target),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_branch_taken(ex_branch_taken), .ex_branch_target(ex_branch_target),
        .ex_mem_write(ex_mem_write), .ex_mem_read(ex_mem_read),
        .ex_reg_write(ex_reg_write), .ex_mem_to_reg(ex_mem_to_reg), .ex_rd(ex_rd)
    );

endmodule

`default_nettype wire

// File: verilog/ex_mem_register.sv
// EX/MEM pipeline register, merges ALU result, branch outcome and pass-through controls into the stage outputs
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module ex_mem_register (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,
    exec_issue_if.commit          issue,

    // Combinational results of the current operation
    input  wire [`EX_XLEN-1:0]    result,
    input  wire                   taken,
    input  wire [`EX_XLEN-1:0]    target,

    output logic [`EX_XLEN-1:0]   ex_result,      // Also the EX/MEM forwarding value
    output logic [`EX_XLEN-1:0]   ex_store_data,
    output logic                  ex_branch_taken,
    output logic [`EX_XLEN-1:0]   ex_branch_target,
    output logic                  ex_mem_write,
    output logic                  ex_mem_read,
    output logic                  ex_reg_write,
    output logic                  ex_mem_to_reg,
    output logic [`EX_REG_AW-1:0] ex_rd
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_result        <= '0;
            ex_store_data    <= '0;
            ex_branch_taken  <= 1'b0;
            ex_branch_target <= '0;
            ex_mem_write     <= 1'b0;
            ex_mem_read      <= 1'b0;
            ex_reg_write     <= 1'b0;
            ex_mem_to_reg    <= 1'b0;
            ex_rd            <= '0;
        end
        else if (!stall)
        begin
            ex_result        <= result;
            ex_store_data    <= issue.rs2;  // Forwarded rs2 is the store value
            ex_branch_taken  <= taken;
            ex_branch_target <= target;
            ex_mem_write     <= issue.mem_write;
            ex_mem_read      <= issue.mem_read;
            ex_reg_write     <= issue.reg_write;
            ex_mem_to_reg    <= issue.mem_to_reg;
            ex_rd            <= issue.rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
// Branch unit, evaluates the branch condition on rs1/rs2 and computes the branch or jump target
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module branch_unit import exec_pkg::*; (
    exec_issue_if.branch          issue,
    output logic                  taken,
    output logic [`EX_XLEN-1:0]   target
);

    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                cond;
    logic [`EX_XLEN-1:0] jalr_sum;

    // Direct compare, independent of the ALU
    assign eq   = issue.rs1 == issue.rs2;
    assign lt_s = $signed(issue.rs1) < $signed(issue.rs2);
    assign lt_u = issue.rs1 < issue.rs2;

    always_comb
    begin
        case (issue.branch_type)
            BR_BEQ:  cond = eq;
            BR_BNE:  cond = !eq;
            BR_BLT:  cond = lt_s;
            BR_BGE:  cond = !lt_s;
            BR_BLTU: cond = lt_u;
            BR_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    // Jumps are unconditional once pc_src is set
    assign taken = issue.pc_src && ((issue.mode != MODE_BRANCH) || cond);

    assign jalr_sum = issue.rs1 + issue.imm;

    always_comb
    begin
        if (issue.mode == MODE_JALR)
            target = {jalr_sum[`EX_XLEN-1:1], 1'b0};  // Bit 0 cleared per ISA
        else
            target = issue.pc + issue.imm;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// Execute stage ALU, picks operands from the operand mode and applies the selected integer operation
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module alu import exec_pkg::*; (
    exec_issue_if.alu             issue,
    output logic [`EX_XLEN-1:0]   result
);

    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [4:0]          shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    // Operand selection
    always_comb
    begin
        case (issue.mode)
            MODE_LOAD_STORE:
            begin
                a = issue.rs1;  // Address = base + offset
                b = issue.imm;
            end
            MODE_BRANCH:
            begin
                a = issue.rs1;
                b = issue.rs2;
            end
            MODE_REG_IMM:
            begin
                a = issue.rs1;
                b = issue.alu_src ? issue.imm : issue.rs2;
            end
            MODE_LUI:
            begin
                a = issue.imm;  // Upper immediate already shifted by decode
                b = '0;
            end
            MODE_AUIPC:
            begin
                a = issue.pc;
                b = issue.imm;
            end
            MODE_JAL, MODE_JALR:
            begin
                // Link value for rd
                a = issue.pc;
                b = `EX_LINK_OFFSET;
            end
            default:
            begin
                a = '0;
                b = '0;
            end
        endcase
    end

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (issue.alu_ctrl)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/id_ex_capture.sv
// ID/EX pipeline register that resolves rs1/rs2 forwarding and drives the captured operation onto the issue bundle
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

module id_ex_capture import exec_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,

    // Decoded operation from ID
    input  wire [`EX_XLEN-1:0]    rs1_value,
    input  wire [`EX_XLEN-1:0]    rs2_value,
    input  wire [`EX_XLEN-1:0]    imm,
    input  wire [`EX_XLEN-1:0]    pc,
    input  wire [`EX_REG_AW-1:0]  rs1_addr,
    input  wire [`EX_REG_AW-1:0]  rs2_addr,
    input  wire                   alu_src,
    input  wire operand_mode_e    mode,
    input  wire alu_ctrl_e        alu_ctrl,
    input  wire branch_type_e     branch_type,
    input  wire                   pc_src,
    input  wire                   mem_write,
    input  wire                   mem_read,
    input  wire                   reg_write,
    input  wire                   mem_to_reg,
    input  wire [`EX_REG_AW-1:0]  rd,

    // EX/MEM forwarding source
    input  wire                   fwd_reg_write,
    input  wire [`EX_REG_AW-1:0]  fwd_rd,
    input  wire [`EX_XLEN-1:0]    fwd_result,

    // MEM/WB forwarding source
    input  wire                   mem_wb_reg_write,
    input  wire [`EX_REG_AW-1:0]  mem_wb_rd,
    input  wire [`EX_XLEN-1:0]    mem_wb_data,

    exec_issue_if.capture         issue
);

    logic [`EX_XLEN-1:0] rs1_fwd;
    logic [`EX_XLEN-1:0] rs2_fwd;

    // Younger EX/MEM write has priority over MEM/WB and x0 never forwards
    function automatic logic [`EX_XLEN-1:0] forward_operand(
        input logic [`EX_REG_AW-1:0] addr,
        input logic [`EX_XLEN-1:0]   rf_value
    );
        if (fwd_reg_write && (fwd_rd != '0) && (fwd_rd == addr))
            return fwd_result;
        else if (mem_wb_reg_write && (mem_wb_rd != '0) && (mem_wb_rd == addr))
            return mem_wb_data;
        else
            return rf_value;
    endfunction

    always_comb
    begin
        rs1_fwd = forward_operand(rs1_addr, rs1_value);
        rs2_fwd = forward_operand(rs2_addr, rs2_value);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            issue.rs1         <= '0;
            issue.rs2         <= '0;
            issue.imm         <= '0;
            issue.pc          <= '0;
            issue.alu_src     <= 1'b0;
            issue.mode        <= MODE_LOAD_STORE;
            issue.alu_ctrl    <= ALU_ADD;
            issue.branch_type <= BR_BEQ;
            issue.pc_src      <= 1'b0;
            issue.mem_write   <= 1'b0;
            issue.mem_read    <= 1'b0;
            issue.reg_write   <= 1'b0;
            issue.mem_to_reg  <= 1'b0;
            issue.rd          <= '0;
        end
        else if (!stall)  // Hold the whole operation on stall
        begin
            issue.rs1         <= rs1_fwd;
            issue.rs2         <= rs2_fwd;
            issue.imm         <= imm;
            issue.pc          <= pc;
            issue.alu_src     <= alu_src;
            issue.mode        <= mode;
            issue.alu_ctrl    <= alu_ctrl;
            issue.branch_type <= branch_type;
            issue.pc_src      <= pc_src;
            issue.mem_write   <= mem_write;
            issue.mem_read    <= mem_read;
            issue.reg_write   <= reg_write;
            issue.mem_to_reg  <= mem_to_reg;
            issue.rd          <= rd;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_issue_if.sv
// Captured operation bundle, driven by the ID/EX register and read by the ALU, branch unit and EX/MEM register
`default_nettype none
`timescale 1ns/100ps
`include "exec_defines.svh"

interface exec_issue_if import exec_pkg::*; ();

    logic [`EX_XLEN-1:0]   rs1;          // Forwarded source operands
    logic [`EX_XLEN-1:0]   rs2;
    logic [`EX_XLEN-1:0]   imm;
    logic [`EX_XLEN-1:0]   pc;
    logic                  alu_src;
    operand_mode_e         mode;
    alu_ctrl_e             alu_ctrl;
    branch_type_e          branch_type;
    logic                  pc_src;       // Set for branches and jumps

    // Controls for the later stages
    logic                  mem_write;
    logic                  mem_read;
    logic                  reg_write;
    logic                  mem_to_reg;
    logic [`EX_REG_AW-1:0] rd;

    modport capture (output rs1, rs2, imm, pc, alu_src, mode, alu_ctrl, branch_type, pc_src,
                      mem_write, mem_read, reg_write, mem_to_reg, rd);

    modport alu (input rs1, rs2, imm, pc, alu_src, mode, alu_ctrl);

    modport branch (input rs1, rs2, imm, pc, mode, branch_type, pc_src);

    modport commit (input rs2, mem_write, mem_read, reg_write, mem_to_reg, rd);

endinterface

`default_nettype wire

// File: verilog/exec_pkg.sv
// Operation, operand mode and branch type enums shared by the execute stage and its testbench
`default_nettype none

package exec_pkg;

    // Exact ALU operation, decoded from funct3/funct7 upstream
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,  // Signed compare, result 1 or 0
        ALU_SLTU = 5'd9   // Unsigned compare
    } alu_ctrl_e;

    // Operand source class, picks the a and b inputs of the ALU
    //   LOAD_STORE  rs1, imm
    //   BRANCH      rs1, rs2
    //   REG_IMM     rs1, imm or rs2 by alu_src
    //   LUI         imm, 0
    //   AUIPC       pc, imm
    //   JAL/JALR    pc, link offset
    typedef enum logic [2:0] {
        MODE_LOAD_STORE = 3'b000,
        MODE_BRANCH     = 3'b001,
        MODE_REG_IMM    = 3'b010,
        MODE_JAL        = 3'b011,
        MODE_LUI        = 3'b100,
        MODE_AUIPC      = 3'b101,
        MODE_JALR       = 3'b111
    } operand_mode_e;

    // Branch condition, encoded as the RISC-V funct3 field
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_type_e;

endpackage

`default_nettype wire

// File: include/exec_defines.svh
// Width and offset macros for the execute stage, included by every RTL file that sizes a datapath
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Integer datapath width
`define EX_XLEN 32

// Register file address width, x0..x31
`define EX_REG_AW 5

// Return address increment for JAL and JALR
// The ALU adds it to pc so rd gets the address of the next instruction
`define EX_LINK_OFFSET 4

`endif
